//--- multdiv_fast.f
+incdir+.
source/multdiv_pkg.sv
source/multdiv_mac.sv
source/multdiv_divider.sv
source/multdiv_fast.sv
testbench/multdiv_fast_asserts.sv
testbench/multdiv_fast_tb.sv

//--- multdiv_macros.svh
// Multiply/divide unit width constants
// Word, half-word, accumulator and division counter sizes

`ifndef MULTDIV_MACROS_SVH
`define MULTDIV_MACROS_SVH

// Operand and result width
`define MD_WORD_W 32

// Half of a word, one multiplier input
`define MD_HALF_W 16

// Multiply-accumulate width, word plus sign and carry
`define MD_ACC_W 34

// Division bit index width
`define MD_CNT_W 5

// First bit index of the long division
`define MD_DIV_STEPS 31

`endif

//--- source/multdiv_divider.sv
// Restoring long divider for signed and unsigned operands
// Works on absolute values, restores the sign at the end
// Zero divisor exits early with the RISC-V results

`timescale 1ns/100ps
`default_nettype none

`include "multdiv_macros.svh"

module multdiv_divider import multdiv_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     en_i,
  input  wire md_req_t  req_i,
  input  wire logic     ready_i,
  output md_word_t      result_o,
  output logic          valid_o
);

  div_state_e state_q, state_d;

  md_cnt_t  cnt_q, cnt_d;
  md_word_t rem_q, rem_d;
  md_word_t num_q, num_d;
  md_word_t den_q, den_d;
  md_word_t quo_q, quo_d;

  logic [`MD_WORD_W:0] adder_a;
  logic [`MD_WORD_W:0] adder_b;
  logic [`MD_WORD_W:0] adder_res;
  md_word_t            adder_h;

  md_word_t next_remainder;
  md_word_t next_quotient;
  md_word_t one_shift;
  logic     is_greater_equal;
  logic     sign_a;
  logic     sign_b;
  logic     div_by_zero;
  logic     div_change_sign;
  logic     rem_change_sign;
  logic     is_div;
  logic     div_valid;
  logic     div_hold;
  logic     div_en_int;

  // Operands carry a trailing one so the carry-in lands in bit 0
  assign adder_res = adder_a + adder_b;
  assign adder_h   = adder_res[`MD_WORD_W:1];

  assign is_div      = (req_i.op == MD_OP_DIV);
  assign div_by_zero = (req_i.op_b == '0);
  assign sign_a      = req_i.op_a[`MD_WORD_W-1] & req_i.signed_mode[0];
  assign sign_b      = req_i.op_b[`MD_WORD_W-1] & req_i.signed_mode[1];

  assign div_change_sign = (sign_a ^ sign_b) & ~div_by_zero;
  assign rem_change_sign = sign_a;

  // Unsigned compare of remainder and divisor from the difference sign
  always_comb begin
    if ((rem_q[`MD_WORD_W-1] ^ den_q[`MD_WORD_W-1]) == 1'b0) begin
      is_greater_equal = ~adder_h[`MD_WORD_W-1];
    end else begin
      is_greater_equal = rem_q[`MD_WORD_W-1];
    end
  end

  assign one_shift      = md_word_t'(1) << cnt_q;
  assign next_remainder = is_greater_equal ? adder_h : rem_q;
  assign next_quotient  = is_greater_equal ? (quo_q | one_shift) : quo_q;

  always_comb begin
    cnt_d     = cnt_q - `MD_CNT_W'(1);
    rem_d     = rem_q;
    num_d     = num_q;
    den_d     = den_q;
    quo_d     = quo_q;
    state_d   = state_q;
    adder_a   = {32'h0, 1'b1};
    adder_b   = {~req_i.op_b, 1'b1};
    div_valid = 1'b0;
    div_hold  = 1'b0;

    unique case (state_q)
      MD_IDLE: begin
        // Preload the divide by zero answer
        rem_d   = is_div ? '1 : req_i.op_a;
        cnt_d   = `MD_CNT_W'(`MD_DIV_STEPS);
        state_d = div_by_zero ? MD_FINISH : MD_ABS_A;
      end

      MD_ABS_A: begin
        // 0 - a
        adder_b = {~req_i.op_a, 1'b1};
        quo_d   = '0;
        num_d   = sign_a ? adder_h : req_i.op_a;
        cnt_d   = `MD_CNT_W'(`MD_DIV_STEPS);
        state_d = MD_ABS_B;
      end

      MD_ABS_B: begin
        // 0 - b
        rem_d   = {31'h0, num_q[`MD_WORD_W-1]};
        den_d   = sign_b ? adder_h : req_i.op_b;
        cnt_d   = `MD_CNT_W'(`MD_DIV_STEPS);
        state_d = MD_COMP;
      end

      MD_COMP: begin
        // Partial remainder stays below the divisor, so its top bit is free
        adder_a = {rem_q, 1'b1};
        adder_b = {~den_q, 1'b1};
        rem_d   = {next_remainder[`MD_WORD_W-2:0], num_q[cnt_d]};
        quo_d   = next_quotient;
        state_d = (cnt_q == `MD_CNT_W'(1)) ? MD_LAST : MD_COMP;
      end

      MD_LAST: begin
        adder_a = {rem_q, 1'b1};
        adder_b = {~den_q, 1'b1};
        // Only one of quotient and remainder is kept from here on
        rem_d   = is_div ? next_quotient : next_remainder;
        state_d = MD_CHANGE_SIGN;
      end

      MD_CHANGE_SIGN: begin
        // 0 - result
        adder_b = {~rem_q, 1'b1};
        if (is_div) begin
          rem_d = div_change_sign ? adder_h : rem_q;
        end else begin
          rem_d = rem_change_sign ? adder_h : rem_q;
        end
        state_d = MD_FINISH;
      end

      MD_FINISH: begin
        div_valid = 1'b1;
        div_hold  = ~ready_i;
        state_d   = MD_IDLE;
      end

      default: begin
        state_d = MD_IDLE;
      end
    endcase
  end

  assign div_en_int = en_i & ~div_hold;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MD_IDLE;
      cnt_q   <= '0;
    end else if (div_en_int) begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (div_en_int) begin
      rem_q <= rem_d;
      num_q <= num_d;
      den_q <= den_d;
      quo_q <= quo_d;
    end
  end

  assign result_o = rem_q;
  assign valid_o  = en_i & div_valid;

endmodule

`default_nettype wire

//--- source/multdiv_fast.sv
// Integer multiply/divide unit, top level
// Steers the request to the multiplier or the divider
// and returns the result of the active one

`timescale 1ns/100ps
`default_nettype none

module multdiv_fast import multdiv_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     en_i,
  input  wire md_req_t  req_i,
  input  wire logic     ready_i,
  output md_word_t      result_o,
  output logic          valid_o
);

  logic     is_mul;
  logic     mul_en;
  logic     div_en;
  logic     mul_valid;
  logic     div_valid;
  md_word_t mul_result;
  md_word_t div_result;

  // Both multiply classes go to the MAC, the rest to the divider
  assign is_mul = (req_i.op == MD_OP_MULL) || (req_i.op == MD_OP_MULH);
  assign mul_en = en_i & is_mul;
  assign div_en = en_i & ~is_mul;

  multdiv_mac u_mac (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (mul_en),
    .req_i    (req_i),
    .ready_i  (ready_i),
    .result_o (mul_result),
    .valid_o  (mul_valid)
  );

  multdiv_divider u_div (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (div_en),
    .req_i    (req_i),
    .ready_i  (ready_i),
    .result_o (div_result),
    .valid_o  (div_valid)
  );

  // Only one unit is enabled at a time
  assign valid_o  = mul_valid | div_valid;
  assign result_o = is_mul ? mul_result : div_result;

endmodule

`default_nettype wire

//--- source/multdiv_mac.sv
// Sequential 16x16 multiply-accumulate unit
// Low product in 3 cycles, high product in 4 cycles

`timescale 1ns/100ps
`default_nettype none

`include "multdiv_macros.svh"

module multdiv_mac import multdiv_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     en_i,
  input  wire md_req_t  req_i,
  input  wire logic     ready_i,
  output md_word_t      result_o,
  output logic          valid_o
);

  mac_state_e state_q, state_d;

  md_acc_t  acc_q;
  md_acc_t  accum;
  md_acc_t  mac_res_d;
  md_half_t mult_op_a;
  md_half_t mult_op_b;
  logic     sign_a;
  logic     sign_b;
  logic     signed_mult;
  logic     mult_valid;
  logic     mult_hold;
  logic     mult_en_int;

  // Top two bits of the 35 bit sum always agree, so 34 bits are exact
  logic signed [`MD_ACC_W-1:0] mac_res;

  assign signed_mult = (req_i.signed_mode != 2'b00);

  assign mac_res = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b})
                 + $signed(accum);

  always_comb begin
    mult_op_a  = req_i.op_a[`MD_HALF_W-1:0];
    mult_op_b  = req_i.op_b[`MD_HALF_W-1:0];
    sign_a     = 1'b0;
    sign_b     = 1'b0;
    accum      = acc_q;
    mac_res_d  = mac_res;
    state_d    = state_q;
    mult_valid = 1'b0;
    mult_hold  = 1'b0;

    unique case (state_q)
      ALBL: begin
        // al*bl, always unsigned
        accum   = '0;
        state_d = ALBH;
      end

      ALBH: begin
        // al*bh, aligned to the upper half of the first product
        mult_op_b = req_i.op_b[`MD_WORD_W-1:`MD_HALF_W];
        sign_b    = req_i.signed_mode[1] & req_i.op_b[`MD_WORD_W-1];
        accum     = {18'b0, acc_q[`MD_WORD_W-1:`MD_HALF_W]};
        if (req_i.op == MD_OP_MULL) begin
          // Keep al*bl low half below the new partial sum
          mac_res_d = {2'b0, mac_res[`MD_HALF_W-1:0], acc_q[`MD_HALF_W-1:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        // ah*bl
        mult_op_a = req_i.op_a[`MD_WORD_W-1:`MD_HALF_W];
        sign_a    = req_i.signed_mode[0] & req_i.op_a[`MD_WORD_W-1];
        if (req_i.op == MD_OP_MULL) begin
          accum      = {18'b0, acc_q[`MD_WORD_W-1:`MD_HALF_W]};
          mac_res_d  = {2'b0, mac_res[`MD_HALF_W-1:0], acc_q[`MD_HALF_W-1:0]};
          mult_valid = 1'b1;
          mult_hold  = ~ready_i;
          state_d    = ALBL;
        end else begin
          state_d = AHBH;
        end
      end

      AHBH: begin
        // ah*bh on the sum shifted down by a half word
        mult_op_a = req_i.op_a[`MD_WORD_W-1:`MD_HALF_W];
        mult_op_b = req_i.op_b[`MD_WORD_W-1:`MD_HALF_W];
        sign_a    = req_i.signed_mode[0] & req_i.op_a[`MD_WORD_W-1];
        sign_b    = req_i.signed_mode[1] & req_i.op_b[`MD_WORD_W-1];
        accum     = {{16{signed_mult & acc_q[`MD_ACC_W-1]}},
                     acc_q[`MD_ACC_W-1:`MD_HALF_W]};
        mult_valid = 1'b1;
        mult_hold  = ~ready_i;
        state_d    = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  // Nothing moves in the final state until the result is taken
  assign mult_en_int = en_i & ~mult_hold;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
    end else if (mult_en_int) begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mult_en_int) begin
      acc_q <= mac_res_d;
    end
  end

  assign result_o = mac_res_d[`MD_WORD_W-1:0];
  assign valid_o  = en_i & mult_valid;

endmodule

`default_nettype wire

//--- source/multdiv_pkg.sv
// Multiply/divide unit types
// Width typedefs, operation classes, request bundle and FSM encodings

`default_nettype none

`include "multdiv_macros.svh"

package multdiv_pkg;

  typedef logic [`MD_WORD_W-1:0] md_word_t;
  typedef logic [`MD_HALF_W-1:0] md_half_t;
  typedef logic [`MD_ACC_W-1:0]  md_acc_t;
  typedef logic [`MD_CNT_W-1:0]  md_cnt_t;

  // Operation class
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // One request, held stable while the enable is high
  typedef struct packed {
    md_op_e     op;
    logic [1:0] signed_mode;
    md_word_t   op_a;
    md_word_t   op_b;
  } md_req_t;

  // Partial product walk of the multiplier
  typedef enum logic [1:0] {
    ALBL, ALBH, AHBL, AHBH
  } mac_state_e;

  typedef enum logic [2:0] {
    MD_IDLE, MD_ABS_A, MD_ABS_B, MD_COMP, MD_LAST, MD_CHANGE_SIGN, MD_FINISH
  } div_state_e;

endpackage

`default_nettype wire

//--- testbench/multdiv_fast_asserts.sv
// Assertions for the multiply/divide unit
// FSM progress, return to idle and result hold under back-pressure

`timescale 1ns/100ps
`default_nettype none

module multdiv_fast_asserts import multdiv_pkg::*; (
  input wire logic       clk_i,
  input wire logic       rst_ni,
  input wire logic       ready_i,
  input wire logic       valid_i,
  input wire md_word_t   result_i,
  input wire logic [1:0] op_i,
  input wire logic [1:0] mac_state_i,
  input wire logic [2:0] div_state_i
);

  // Number of failed assertions
  int fail_count = 0;

  // Only a high product walks on to the fourth partial product
  mac_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mac_state_i == AHBH) |-> (op_i == MD_OP_MULH))
    else begin
      fail_count++;
      $error("Multiplier reached ah*bh for an operation other than a high product");
    end

  div_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    div_state_i inside {MD_IDLE, MD_ABS_A, MD_ABS_B, MD_COMP, MD_LAST,
                        MD_CHANGE_SIGN, MD_FINISH})
    else begin
      fail_count++;
      $error("Divider state register holds an illegal value");
    end

  // An accepted result sends both units back to their first state
  first_state_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && ready_i) |=> (mac_state_i == ALBL && div_state_i == MD_IDLE))
    else begin
      fail_count++;
      $error("A unit did not return to its first state after acceptance");
    end

  // A result not yet taken stays put
  result_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && !ready_i) |=> (valid_i && $stable(result_i)))
    else begin
      fail_count++;
      $error("valid_o or result_o changed under back-pressure");
    end

endmodule

bind multdiv_fast multdiv_fast_asserts asserts0 (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .ready_i     (ready_i),
  .valid_i     (valid_o),
  .result_i    (result_o),
  .op_i        (req_i.op),
  .mac_state_i (u_mac.state_q),
  .div_state_i (u_div.state_q)
);

`default_nettype wire

//--- testbench/multdiv_fast_tb.sv
// Testbench for the integer multiply/divide unit
// Applies a table of fixed and random requests and checks result,
// latency and result hold under back-pressure

`timescale 1ns/100ps
`default_nettype none

module multdiv_fast_tb;

  import multdiv_pkg::*;

  localparam int NUM_FIXED  = 18;
  localparam int NUM_RANDOM = 8;
  localparam int NUM_ROWS   = NUM_FIXED + NUM_RANDOM;
  localparam int WAIT_LIMIT = 64;

  logic     clk_i;
  logic     rst_ni;
  logic     en_i;
  logic     ready_i;
  md_req_t  req_i;
  md_word_t result_o;
  logic     valid_o;

  // Stimulus and expected values, one entry per request
  md_op_e     row_op   [NUM_ROWS];
  logic [1:0] row_mode [NUM_ROWS];
  md_word_t   row_a    [NUM_ROWS];
  md_word_t   row_b    [NUM_ROWS];
  int         row_bp   [NUM_ROWS];
  int         row_lat  [NUM_ROWS];
  md_word_t   row_exp  [NUM_ROWS];

  int     errors;
  integer seed;

  multdiv_fast dut0 (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (en_i),
    .req_i    (req_i),
    .ready_i  (ready_i),
    .result_o (result_o),
    .valid_o  (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  // RISC-V result from 64-bit arithmetic on the extended operands
  function automatic md_word_t reference_result(input md_op_e op, input logic [1:0] mode,
                                                input md_word_t a, input md_word_t b);
    logic signed [63:0] ax;
    logic signed [63:0] bx;
    logic signed [63:0] full;
    ax = mode[0] ? {{32{a[31]}}, a} : {32'h0, a};
    bx = mode[1] ? {{32{b[31]}}, b} : {32'h0, b};
    case (op)
      MD_OP_MULL: full = ax * bx;
      MD_OP_MULH: full = (ax * bx) >>> 32;
      MD_OP_DIV: begin
        if (b == '0) begin
          full = 64'hFFFF_FFFF;
        end else begin
          full = ax / bx;
        end
      end
      default: begin
        if (b == '0) begin
          full = {32'h0, a};
        end else begin
          full = ax % bx;
        end
      end
    endcase
    return full[31:0];
  endfunction

  function automatic int expected_latency(input md_op_e op, input md_word_t b);
    if (op == MD_OP_MULL) return 3;
    if (op == MD_OP_MULH) return 4;
    return (b == '0) ? 2 : 37;
  endfunction

  task automatic set_row(input int idx, input md_op_e op, input logic [1:0] mode,
                         input md_word_t a, input md_word_t b, input int bp,
                         input int lat, input md_word_t exp);
    row_op[idx]   = op;
    row_mode[idx] = mode;
    row_a[idx]    = a;
    row_b[idx]    = b;
    row_bp[idx]   = bp;
    row_lat[idx]  = lat;
    row_exp[idx]  = exp;
  endtask

  task automatic load_table();
    set_row(0,  MD_OP_MULL, 2'b00, 32'h0000_0007, 32'h0000_0006, 0, 3,  32'h0000_002A);
    set_row(1,  MD_OP_MULL, 2'b11, 32'hFFFF_FFFD, 32'h0000_0005, 0, 3,  32'hFFFF_FFF1);
    set_row(2,  MD_OP_MULL, 2'b01, 32'h1234_5678, 32'h0001_0000, 2, 3,  32'h5678_0000);
    set_row(3,  MD_OP_MULL, 2'b10, 32'h0000_FFFF, 32'h0000_FFFF, 0, 3,  32'hFFFE_0001);
    set_row(4,  MD_OP_MULH, 2'b11, 32'h8000_0000, 32'h8000_0000, 0, 4,  32'h4000_0000);
    set_row(5,  MD_OP_MULH, 2'b11, 32'hFFFF_FFFF, 32'h0000_0002, 0, 4,  32'hFFFF_FFFF);
    set_row(6,  MD_OP_MULH, 2'b01, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 3, 4,  32'hFFFF_FFFF);
    set_row(7,  MD_OP_MULH, 2'b00, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0, 4,  32'hFFFF_FFFE);
    set_row(8,  MD_OP_DIV,  2'b11, 32'hFFFF_FFEC, 32'h0000_0003, 0, 37, 32'hFFFF_FFFA);
    set_row(9,  MD_OP_REM,  2'b11, 32'hFFFF_FFEC, 32'h0000_0003, 0, 37, 32'hFFFF_FFFE);
    set_row(10, MD_OP_DIV,  2'b00, 32'hFFFF_FFEC, 32'h0000_0003, 0, 37, 32'h5555_554E);
    set_row(11, MD_OP_REM,  2'b00, 32'hFFFF_FFEC, 32'h0000_0003, 2, 37, 32'h0000_0002);
    set_row(12, MD_OP_DIV,  2'b11, 32'h8000_0000, 32'hFFFF_FFFF, 0, 37, 32'h8000_0000);
    set_row(13, MD_OP_REM,  2'b11, 32'h8000_0000, 32'hFFFF_FFFF, 0, 37, 32'h0000_0000);
    set_row(14, MD_OP_DIV,  2'b11, 32'h0000_0011, 32'hFFFF_FFFB, 0, 37, 32'hFFFF_FFFD);
    set_row(15, MD_OP_REM,  2'b11, 32'h0000_0011, 32'hFFFF_FFFB, 1, 37, 32'h0000_0002);
    set_row(16, MD_OP_DIV,  2'b11, 32'h1234_5678, 32'h0000_0000, 1, 2,  32'hFFFF_FFFF);
    set_row(17, MD_OP_REM,  2'b00, 32'h1234_5678, 32'h0000_0000, 0, 2,  32'h1234_5678);
    for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
      row_op[i]   = md_op_e'(2'($random(seed)));
      row_mode[i] = 2'($random(seed));
      row_a[i]    = $random(seed);
      row_b[i]    = $random(seed);
      row_bp[i]   = $random(seed) & 3;
      row_lat[i]  = expected_latency(row_op[i], row_b[i]);
      row_exp[i]  = reference_result(row_op[i], row_mode[i], row_a[i], row_b[i]);
    end
  endtask

  // One request from enable to acceptance, then one idle cycle
  task automatic run_row(input int idx);
    md_req_t  req;
    md_word_t first_result;
    int       cycle;
    req.op          = row_op[idx];
    req.signed_mode = row_mode[idx];
    req.op_a        = row_a[idx];
    req.op_b        = row_b[idx];
    @(posedge clk_i);
    en_i    <= 1'b1;
    req_i   <= req;
    ready_i <= (row_bp[idx] == 0);
    cycle = 1;
    @(negedge clk_i);
    while (!valid_o && cycle < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycle++;
    end
    if (!valid_o) begin
      errors++;
      $display("Row %0d: valid_o did not rise within %0d cycles", idx, WAIT_LIMIT);
    end else begin
      check_value($sformatf("valid_o latency row %0d", idx), 32'(cycle), 32'(row_lat[idx]));
      check_value($sformatf("result_o row %0d", idx), result_o, row_exp[idx]);
      first_result = result_o;
      if (row_bp[idx] > 0) begin
        repeat (row_bp[idx]) begin
          @(negedge clk_i);
          check_value("valid_o", 32'(valid_o), 32'h1);
          check_value("result_o", result_o, first_result);
        end
        @(posedge clk_i);
        ready_i <= 1'b1;
        @(negedge clk_i);
        check_value("valid_o", 32'(valid_o), 32'h1);
        check_value("result_o", result_o, first_result);
      end
    end
    @(posedge clk_i);
    en_i    <= 1'b0;
    ready_i <= 1'b0;
    @(negedge clk_i);
    check_value("valid_o", 32'(valid_o), 32'h0);
  endtask

  initial begin
    errors  = 0;
    seed    = 75;
    rst_ni  = 1'b0;
    en_i    = 1'b0;
    ready_i = 1'b0;
    req_i   = '0;
    load_table();
    // Hand-filled rows must agree with the reference model
    for (int i = 0; i < NUM_FIXED; i++) begin
      check_value($sformatf("expected result row %0d", i), row_exp[i],
                  reference_result(row_op[i], row_mode[i], row_a[i], row_b[i]));
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("valid_o", 32'(valid_o), 32'h0);
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    errors += dut0.asserts0.fail_count;
    $display("Ran %0d requests, %0d errors", NUM_ROWS, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
